// ==== tb.f ====
rtl/freq_counter_pkg.sv
rtl/gate_generator.sv
rtl/edge_counter.sv
rtl/frequency_scaler.sv
rtl/bin_to_bcd.sv
rtl/segment_display_driver.sv
rtl/frequency_counter_top.sv
sim/tb_frequency_counter.sv

// ==== Makefile ====
# Verilator build and run of the frequency counter testbench

top := tb_frequency_counter

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails on a failing check"
	@echo "  clean  remove the build directory"
	@echo "  help   this list"

test:
	verilator --binary --timing -j 0 -f tb.f --top-module $(top) -Mdir obj_dir
	./obj_dir/V$(top)

clean:
	rm -rf obj_dir

// ==== sim/tb_frequency_counter.sv ====
// ##############################
// frequency counter testbench
// directed tests, lfsr and reference model
// ##############################

`timescale 1ns/1ns
`default_nettype none

module tb_frequency_counter
	import freq_counter_pkg::*;
();

	localparam int log2_gate = 8;
	localparam int ref_khz = 125000;
	localparam int log2_scan = 2;
	localparam int max_wait = 2000;
	// tick patterns
	localparam int mode_none = 0;
	localparam int mode_every = 1;
	localparam int mode_third = 2;
	localparam int mode_outside = 3;
	localparam int mode_lfsr = 4;

	logic clock;
	logic reset;
	logic tick;
	logic gate_out;
	reading_t reading;
	logic [digit_count-1:0] anode;
	segment_t segments;

	// ticks the model saw inside the open gate
	int model_count;
	int cycle_count;
	logic [31:0] lfsr_state;
	// digits of the last expected reading
	bcd_t last_digits;

	frequency_counter_top #(
		.log2_gate(log2_gate),
		.ref_khz(ref_khz),
		.log2_scan(log2_scan)
	) DUT (
		.clock(clock), .reset(reset), .tick(tick), .gate_out(gate_out),
		.reading(reading), .anode(anode), .segments(segments)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// count times reference, divided by the window length
	function automatic bcd_t expected_digits(input int count);
		longint value;
		bcd_t digits;
		value = (longint'(count) * longint'(ref_khz)) >>> log2_gate;
		for (int i = 0; i < digit_count; i++) begin
			digits[4*i +: 4] = 4'(value % 10);
			value = value / 10;
		end
		return digits;
	endfunction

	// position of the lit anode
	function automatic int anode_index(input logic [digit_count-1:0] value);
		int index;
		index = 0;
		for (int i = 0; i < digit_count; i++) begin
			if (value[i]) index = i;
		end
		return index;
	endfunction

	task automatic compare_reading(input string name, input bcd_t actual, input bcd_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic compare_segments(input string name, input segment_t actual,
			input segment_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic compare_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// one clock, then drive the tick for the next edge
	task automatic step_cycle(input int mode);
		logic next_tick;
		@(posedge clock);
		#1;
		cycle_count++;
		case (mode)
			mode_every: next_tick = 1'b1;
			mode_third: next_tick = (cycle_count % 3 == 0);
			mode_outside: next_tick = ~gate_out;
			mode_lfsr: begin
				lfsr_state = lfsr_step(lfsr_state);
				next_tick = lfsr_state[0];
			end
			default: next_tick = 1'b0;
		endcase
		tick = next_tick;
		// gate_out now is what the next edge sees
		if (next_tick && gate_out) model_count++;
	endtask

	task automatic run_until_gate(input int mode, input logic level);
		int cycles;
		cycles = 0;
		while (gate_out !== level) begin
			if (cycles == max_wait) begin
				$display("gate_out never reached %b within %0d cycles at %0t",
					level, max_wait, $time);
				$display("** FAIL **");
				$fatal(1);
			end
			step_cycle(mode);
			cycles++;
		end
	endtask

	task automatic wait_reading();
		for (int i = 0; i < max_wait; i++) begin
			if (reading.valid === 1'b1) return;
			@(posedge clock);
			#1;
		end
		$display("no reading arrived within %0d cycles at %0t", max_wait, $time);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// skip to a fresh window, tick through it, check the reading
	task automatic measure_window(input int mode);
		run_until_gate(mode_none, 1'b0);
		model_count = 0;
		run_until_gate(mode, 1'b1);
		run_until_gate(mode, 1'b0);
		tick = 1'b0;
		wait_reading();
		last_digits = expected_digits(model_count);
		compare_reading("reading.digits", reading.digits, last_digits);
	endtask

	task automatic test_reset();
		compare_bit("gate_out", gate_out, 1'b0);
		compare_segments("segments", segments, digit_segments(4'd0));
		// first window is still closed
		for (int i = 0; i < (1 << log2_gate); i++) begin
			compare_bit("reading.valid", reading.valid, 1'b0);
			step_cycle(mode_none);
		end
	endtask

	task automatic test_every_cycle();
		measure_window(mode_every);
		// full window of 256 at 125 MHz
		compare_reading("reading.digits", reading.digits, 32'h0012_5000);
	endtask

	task automatic test_every_third();
		measure_window(mode_third);
		measure_window(mode_third);
	endtask

	task automatic test_no_ticks();
		measure_window(mode_none);
		compare_reading("reading.digits", reading.digits, '0);
		// ticks only in the closed half
		measure_window(mode_outside);
		compare_reading("reading.digits", reading.digits, '0);
	endtask

	task automatic test_lfsr_ticks();
		for (int i = 0; i < 3; i++) begin
			measure_window(mode_lfsr);
		end
	endtask

	task automatic test_display_scan();
		int prev_index;
		int index;
		int changes;
		// held digits settle, then segments follow
		step_cycle(mode_none);
		step_cycle(mode_none);
		prev_index = -1;
		changes = 0;
		for (int i = 0; i < 32 * (1 << log2_scan); i++) begin
			compare_bit("anode one-hot", $onehot(anode), 1'b1);
			index = anode_index(anode);
			compare_segments("segments", segments, digit_segments(last_digits[4*index +: 4]));
			if (prev_index >= 0 && index != prev_index) begin
				compare_bit("digit index step", index == (prev_index + 1) % digit_count, 1'b1);
				changes++;
			end
			prev_index = index;
			step_cycle(mode_none);
		end
		compare_bit("scan advancing", changes >= 31, 1'b1);
	endtask

	initial begin
		reset = 1'b1;
		tick = 1'b0;
		model_count = 0;
		cycle_count = 0;
		lfsr_state = 32'hd2707ef3;
		last_digits = '0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset();
		test_every_cycle();
		test_every_third();
		test_no_ticks();
		test_lfsr_ticks();
		test_display_scan();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/frequency_counter_top.sv ====
// ##############################
// frequency counter top level
// ##############################

`timescale 1ns/1ns
`default_nettype none

module frequency_counter_top
	import freq_counter_pkg::*;
#(
	parameter int log2_gate = 20,
	parameter int ref_khz = 100000,
	parameter int log2_scan = 12
) (
	input logic clock,
	input logic reset,
	input logic tick,
	output logic gate_out,
	output reading_t reading,
	output logic [digit_count-1:0] anode,
	output segment_t segments
);

	logic gate;
	logic gate_closed;
	measurement_t measurement;
	frequency_t frequency;

	// window timing
	gate_generator #(.log2_gate(log2_gate)) gate_generator_inst (
		.clock(clock), .reset(reset),
		.gate(gate), .gate_closed(gate_closed)
	);

	// ticks per window
	edge_counter edge_counter_inst (
		.clock(clock), .reset(reset), .tick(tick),
		.gate(gate), .gate_closed(gate_closed), .measurement(measurement)
	);

	// count to kHz, two cycles
	frequency_scaler #(.log2_gate(log2_gate), .ref_khz(ref_khz)) frequency_scaler_inst (
		.clock(clock), .reset(reset),
		.measurement(measurement), .frequency(frequency)
	);

	// kHz to decimal, 25 cycles
	bin_to_bcd bin_to_bcd_inst (
		.clock(clock), .reset(reset),
		.frequency(frequency), .reading(reading)
	);

	segment_display_driver #(.log2_scan(log2_scan)) segment_display_driver_inst (
		.clock(clock), .reset(reset), .reading(reading),
		.anode(anode), .segments(segments)
	);

	// gate brought out for a scope or a trigger
	assign gate_out = gate;

endmodule

`default_nettype wire

// ==== rtl/segment_display_driver.sv ====
// ##############################
// multiplexed seven-segment driver
// holds the reading, scans eight digits
// ##############################

`timescale 1ns/1ns
`default_nettype none

module segment_display_driver
	import freq_counter_pkg::*;
#(
	parameter int log2_scan = 12
) (
	input logic clock,
	input logic reset,
	input reading_t reading,
	output logic [digit_count-1:0] anode,
	output segment_t segments
);

	localparam int index_width = $clog2(digit_count);
	localparam logic [digit_count-1:0] first_anode = digit_count'(1);

	// last valid reading
	bcd_t held_digits;
	// cycles spent on the current digit
	logic [log2_scan-1:0] prescale;
	// digit being shown
	logic [index_width-1:0] digit_index;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_digits <= '0;
		end else if (reading.valid) begin
			held_digits <= reading.digits;
		end
	end

	// step to the next digit once the prescaler wraps
	always_ff @(posedge clock) begin
		if (reset) begin
			prescale <= '0;
			digit_index <= '0;
		end else begin
			prescale <= prescale + log2_scan'(1);
			if (&prescale) begin
				// wraps from digit 7 to digit 0
				digit_index <= digit_index + index_width'(1);
			end
		end
	end

	// anode and segments change together, no ghosting
	always_ff @(posedge clock) begin
		if (reset) begin
			anode <= '0;
			segments <= digit_segments(4'd0);
		end else begin
			anode <= first_anode << digit_index;
			segments <= digit_segments(held_digits[4*digit_index +: 4]);
		end
	end

	// the anode trails the index by one cycle
	// digit 0 lights one cycle after reset goes away

endmodule

`default_nettype wire

// ==== rtl/bin_to_bcd.sv ====
// ##############################
// serial binary to bcd converter
// shift-and-add-3, one bit per cycle
// ##############################

`timescale 1ns/1ns
`default_nettype none

module bin_to_bcd
	import freq_counter_pkg::*;
(
	input logic clock,
	input logic reset,
	input frequency_t frequency,
	output reading_t reading
);

	localparam int bcd_width = digit_count*4;
	localparam int shift_width = bcd_width + freq_width;
	localparam logic [4:0] last_step = 5'(freq_width-1);

	// bcd digits on top, binary value shifting out below
	logic [shift_width-1:0] shift_reg;
	// digits corrected, before the shift
	logic [shift_width-1:0] adjusted;
	// next shift register value
	logic [shift_width-1:0] shifted;
	logic [4:0] step;
	logic busy;

	// add 3 to every digit of 5 or more so the shift carries into the next
	always_comb begin
		adjusted = shift_reg;
		for (int i = 0; i < digit_count; i++) begin
			if (adjusted[freq_width+4*i +: 4] >= 4'd5) begin
				adjusted[freq_width+4*i +: 4] = adjusted[freq_width+4*i +: 4] + 4'd3;
			end
		end
		shifted = {adjusted[shift_width-2:0], 1'b0};
	end

	// load on a new value, otherwise shift while busy
	always_ff @(posedge clock) begin
		if (busy) begin
			shift_reg <= shifted;
		end else if (frequency.valid) begin
			shift_reg <= {{bcd_width{1'b0}}, frequency.khz};
		end
	end

	// step sequencing and result
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			step <= '0;
			reading <= '0;
		end else begin
			reading.valid <= 1'b0;
			if (busy) begin
				step <= step + 5'd1;
				if (step == last_step) begin
					// last shift lands straight in the output
					busy <= 1'b0;
					reading.valid <= 1'b1;
					reading.digits <= shifted[shift_width-1:freq_width];
				end
			end else if (frequency.valid) begin
				// a value during a conversion is dropped
				busy <= 1'b1;
				step <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/frequency_scaler.sv ====
// ##############################
// event count to kHz
// multiply then shift, two stages
// ##############################

`timescale 1ns/1ns
`default_nettype none

module frequency_scaler
	import freq_counter_pkg::*;
#(
	parameter int log2_gate = 20,
	parameter int ref_khz = 100000
) (
	input logic clock,
	input logic reset,
	input measurement_t measurement,
	output frequency_t frequency
);

	localparam int product_width = 42;
	// reference clock in kHz at the product width
	localparam logic [product_width-1:0] ref_factor = product_width'(ref_khz);

	// count times reference frequency
	logic [product_width-1:0] product;
	logic product_valid;

	// first stage, the multiply
	always_ff @(posedge clock) begin
		if (measurement.valid) begin
			product <= product_width'(measurement.count) * ref_factor;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			product_valid <= 1'b0;
		end else begin
			product_valid <= measurement.valid;
		end
	end

	// second stage, divide by the window length
	// truncation to 24 bits is safe for any ref_khz below 2**24
	always_ff @(posedge clock) begin
		if (reset) begin
			frequency <= '0;
		end else begin
			frequency.valid <= product_valid;
			if (product_valid) begin
				frequency.khz <= freq_t'(product >> log2_gate);
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/edge_counter.sv ====
// ##############################
// event counter inside the gate
// latches the total when the gate closes
// ##############################

`timescale 1ns/1ns
`default_nettype none

module edge_counter
	import freq_counter_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic tick,
	input logic gate,
	input logic gate_closed,
	output measurement_t measurement
);

	// ticks seen so far in the open window
	count_t running_count;

	// count only while the gate is open
	always_ff @(posedge clock) begin
		if (reset) begin
			running_count <= '0;
		end else if (gate_closed) begin
			// fresh start for the next window
			running_count <= '0;
		end else if (gate && tick) begin
			running_count <= running_count + count_t'(1);
		end
	end

	// total of the finished window, valid for one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			measurement <= '0;
		end else begin
			measurement.valid <= 1'b0;
			if (gate_closed) begin
				measurement.valid <= 1'b1;
				measurement.count <= running_count;
			end
		end
	end

	// gate is low on the closing cycle, so no tick is lost here
	// ticks outside the window never reach the counter

endmodule

`default_nettype wire

// ==== rtl/gate_generator.sv ====
// ##############################
// counting window generator
// gate level and gate closing pulse
// ##############################

`timescale 1ns/1ns
`default_nettype none

module gate_generator #(
	parameter int log2_gate = 20
) (
	input logic clock,
	input logic reset,
	output logic gate,
	output logic gate_closed
);

	// one bit wider than the half period, top bit is the gate
	logic [log2_gate:0] window_counter;
	// gate as seen one cycle earlier
	logic gate_delayed;

	// free-running, wraps back into the closed half
	always_ff @(posedge clock) begin
		if (reset) begin
			window_counter <= '0;
		end else begin
			window_counter <= window_counter + (log2_gate+1)'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			gate_delayed <= 1'b0;
		end else begin
			gate_delayed <= gate;
		end
	end

	assign gate = window_counter[log2_gate];
	// falling edge of the gate
	assign gate_closed = gate_delayed & ~gate;

endmodule

`default_nettype wire

// ==== rtl/freq_counter_pkg.sv ====
// ##############################
// widths, types and structs of the frequency counter
// seven-segment decode function
// ##############################

`default_nettype none

package freq_counter_pkg;

	// raw event count over one window
	localparam int count_width = 28;
	// scaled frequency in kHz
	localparam int freq_width = 24;
	// decimal digits on the display
	localparam int digit_count = 8;

	typedef logic [count_width-1:0] count_t;
	typedef logic [freq_width-1:0] freq_t;
	// digit 0 in the low nybble
	typedef logic [digit_count*4-1:0] bcd_t;
	// segments g..a, a in bit 0, active high
	typedef logic [6:0] segment_t;

	typedef struct packed {
		logic valid;
		count_t count;
	} measurement_t;

	typedef struct packed {
		logic valid;
		freq_t khz;
	} frequency_t;

	typedef struct packed {
		logic valid;
		bcd_t digits;
	} reading_t;

	// usual 0-9 patterns, anything else blank
	function automatic segment_t digit_segments(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'h3f;
			4'd1: return 7'h06;
			4'd2: return 7'h5b;
			4'd3: return 7'h4f;
			4'd4: return 7'h66;
			4'd5: return 7'h6d;
			4'd6: return 7'h7d;
			4'd7: return 7'h07;
			4'd8: return 7'h7f;
			4'd9: return 7'h6f;
			default: return 7'h00;
		endcase
	endfunction

endpackage

`default_nettype wire
